//--- wfd_pkg.sv
// shared widths, counts and stream types for the digitizer trigger and readout path
`default_nettype none

package wfd_pkg;

    //////////////////////////////
    // sizes

    localparam int NUM_CHAN        = 5;  // channel boards on the master
    localparam int TRIG_NUM_W      = 24; // trigger number width
    localparam int CHAN_DATA_W     = 32; // channel return word width
    localparam int TRIG_FIFO_DEPTH = 4;  // trigger numbers waiting for readout
    localparam int DAQ_FIFO_DEPTH  = 8;  // output buffer towards the DAQ link

    // cycles after the acq pulse before done levels are trusted again,
    // covers the channel dropping its old done plus the 2-flop synchronizer
    localparam int DONE_HOLDOFF = 4;
    localparam int HOLDOFF_W    = $clog2(DONE_HOLDOFF + 1);

    //////////////////////////////
    // types

    typedef logic [NUM_CHAN-1:0]           chan_mask_t; // one bit per channel
    typedef logic [$clog2(NUM_CHAN)-1:0]   chan_idx_t;  // channel number
    typedef logic [$clog2(NUM_CHAN+1)-1:0] chan_cnt_t;  // 0 .. NUM_CHAN
    typedef logic [TRIG_NUM_W-1:0]         trig_num_t;

    // word on a channel return stream
    typedef struct packed {
        logic [CHAN_DATA_W-1:0] data;
        logic                   last; // final word of the channel packet
    } chan_beat_t;

    // word on the DAQ output stream
    typedef struct packed {
        logic                   header;  // first word of an event
        logic                   trailer; // final word of an event
        logic [CHAN_DATA_W-1:0] data;
    } daq_word_t;

endpackage

`default_nettype wire

//--- trigger_manager.sv
// trigger control FSM that fires the channels on a front-panel trigger and queues its number
`timescale 1ns/10ps
`default_nettype none

module trigger_manager
    import wfd_pkg::*;
(
    input  logic       clk125,    // 125 MHz system clock
    input  logic       arst_n,
    input  logic       ext_trig,  // front-panel trigger, async level
    input  chan_mask_t acq_dones, // done levels from the channel boards, async
    input  chan_mask_t chan_en,   // static enable mask
    output chan_mask_t acq_trigs, // one-cycle acquisition pulse
    output chan_mask_t trig_arm,  // arm level to the channels
    output logic       num_valid, // towards trig_fifo
    output trig_num_t  num,
    input  logic       num_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,      // armed, waiting for a trigger edge
        ST_WAIT_DONE, // channels are acquiring
        ST_PUSH_NUM   // number offered to the FIFO
    } tm_state_t;

    tm_state_t state;

    logic                 trig_meta; // first sync stage
    logic                 trig_sync; // second sync stage
    logic                 trig_prev; // edge detector history
    chan_mask_t           done_meta;
    chan_mask_t           done_sync;
    logic [HOLDOFF_W-1:0] holdoff;   // ignore stale done levels while nonzero
    logic                 trig_rise;
    logic                 accept;
    logic                 all_done;

    //////////////////////////////
    // trigger qualification

    assign trig_rise = trig_sync & ~trig_prev;
    assign accept    = trig_rise && (state == ST_IDLE) && num_ready; // else dropped

    // every enabled channel reports done and disabled bits are ignored
    assign all_done = ((done_sync & chan_en) == chan_en) && (holdoff == '0);

    assign trig_arm  = (state == ST_IDLE) ? chan_en : '0; // low from the pulse on
    assign num_valid = (state == ST_PUSH_NUM);

    //////////////////////////////
    // synchronizers, pulse and FSM

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            trig_meta <= 1'b0;
            trig_sync <= 1'b0;
            trig_prev <= 1'b0;
            done_meta <= '0;
            done_sync <= '0;
            acq_trigs <= '0;
            holdoff   <= '0;
            num       <= '0;         // first accepted trigger becomes 1
            state     <= ST_IDLE;
        end else begin
            trig_meta <= ext_trig;
            trig_sync <= trig_meta;
            trig_prev <= trig_sync;
            done_meta <= acq_dones;
            done_sync <= done_meta;

            acq_trigs <= accept ? chan_en : '0; // single cycle, enabled bits only

            if (holdoff != '0) begin
                holdoff <= holdoff - 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        num     <= num + 1'b1;
                        holdoff <= HOLDOFF_W'(DONE_HOLDOFF);
                        state   <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    if (all_done) begin
                        state <= ST_PUSH_NUM;
                    end
                end
                ST_PUSH_NUM: begin
                    if (num_ready) begin
                        state <= ST_IDLE; // number taken, re-arm
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- axis_fifo.sv
// valid/ready FIFO for any payload type; holds trigger numbers and buffers DAQ words
`timescale 1ns/10ps
`default_nettype none

module axis_fifo #(
    parameter type payload_t = logic [31:0], // word carried through
    parameter int  DEPTH     = 4             // number of entries
) (
    input  logic     clk125,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,   // room for one more word
    output logic     out_valid,  // at least one word stored
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t                   mem [DEPTH]; // circular buffer, no reset
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;       // words held
    logic                       wr_en;
    logic                       rd_en;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    assign in_ready  = (count != ($clog2(DEPTH+1))'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr]; // straight from storage, no path from in_data

    always_ff @(posedge clk125) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- chan_rx_arbiter.sv
// round-robin packet arbiter merging the channel return streams into the event builder stream
`timescale 1ns/10ps
`default_nettype none

module chan_rx_arbiter
    import wfd_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    input  chan_mask_t chan_valid,           // per-channel request
    input  chan_beat_t chan_beat [NUM_CHAN], // per-channel word
    output chan_mask_t chan_ready,           // only the granted channel sees ready
    output logic       out_valid,            // merged stream
    output chan_beat_t out_beat,
    input  logic       out_ready
);

    chan_idx_t ptr;        // last channel that finished a packet
    chan_idx_t grant;      // channel owning the stream mid-packet
    logic      locked;     // a packet is in flight
    chan_idx_t pick;       // next requester after ptr
    logic      pick_found;
    chan_idx_t sel;        // channel routed this cycle
    logic      active;

    //////////////////////////////
    // round-robin search

    always_comb begin
        int unsigned cand;

        pick_found = 1'b0;
        pick       = ptr;
        for (int i = 1; i <= NUM_CHAN; i++) begin
            cand = (int'(ptr) + i) % NUM_CHAN; // start one past the last winner
            if (!pick_found && chan_valid[cand]) begin
                pick_found = 1'b1;
                pick       = chan_idx_t'(cand);
            end
        end
    end

    assign sel    = locked ? grant : pick;  // stay on the packet owner
    assign active = locked || pick_found;

    //////////////////////////////
    // stream mux, combinational in both directions

    assign out_valid = chan_valid[sel]; // no request leaves sel pointing at an idle channel
    assign out_beat  = chan_beat[sel];

    always_comb begin
        chan_ready = '0;
        if (active) begin
            chan_ready[sel] = out_ready;
        end
    end

    // lock on the first word, release once last has gone through
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            ptr    <= chan_idx_t'(NUM_CHAN - 1); // first search starts at channel 0
            grant  <= '0;
            locked <= 1'b0;
        end else if (out_valid && out_ready) begin
            if (out_beat.last) begin
                locked <= 1'b0;
                ptr    <= sel;    // round-robin moves on from here
            end else begin
                locked <= 1'b1;
                grant  <= sel;
            end
        end
    end

endmodule

`default_nettype wire

//--- event_builder.sv
// event framing with a numbered header, one packet per enabled channel and a trailer flag
`timescale 1ns/10ps
`default_nettype none

module event_builder
    import wfd_pkg::*;
(
    input  logic       clk125,
    input  logic       arst_n,
    input  chan_mask_t chan_en,    // static enable mask
    input  logic       num_valid,  // from trig_fifo
    input  trig_num_t  num,
    output logic       num_ready,
    input  logic       beat_valid, // merged channel stream
    input  chan_beat_t beat,
    output logic       beat_ready,
    output logic       daq_valid,  // towards daq_fifo
    output daq_word_t  daq_word,
    input  logic       daq_ready
);

    typedef enum logic {
        EB_HEADER, // waiting for the next trigger number
        EB_BODY    // forwarding channel packets
    } eb_state_t;

    eb_state_t state;
    chan_cnt_t need;      // packets expected per event
    chan_cnt_t seen;      // packets finished in this event
    logic      last_pkt;  // current word closes the event

    assign need     = chan_cnt_t'($countones(chan_en));
    assign last_pkt = beat.last && ((seen + 1'b1) == need);

    //////////////////////////////
    // output word select

    always_comb begin
        daq_valid  = 1'b0;
        daq_word   = '0;
        num_ready  = 1'b0;
        beat_ready = 1'b0;
        case (state)
            EB_HEADER: begin
                daq_valid        = num_valid;
                daq_word.header  = 1'b1;
                daq_word.trailer = (need == '0);          // empty event is header only
                daq_word.data    = CHAN_DATA_W'(num);     // zero-extended
                num_ready        = daq_ready;             // pop as the header leaves
            end
            EB_BODY: begin
                daq_valid        = beat_valid;
                daq_word.trailer = last_pkt;
                daq_word.data    = beat.data;
                beat_ready       = daq_ready;             // stall passes back to arbiter
            end
            default: begin
                daq_valid = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // packet counting

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state <= EB_HEADER;
            seen  <= '0;
        end else begin
            case (state)
                EB_HEADER: begin
                    if (num_valid && daq_ready) begin
                        seen <= '0;
                        if (need != '0) begin
                            state <= EB_BODY;
                        end
                    end
                end
                EB_BODY: begin
                    if (beat_valid && daq_ready && beat.last) begin
                        if (last_pkt) begin
                            state <= EB_HEADER; // trailer sent, next event
                            seen  <= '0;
                        end else begin
                            seen  <= seen + 1'b1;
                        end
                    end
                end
                default: state <= EB_HEADER;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- wfd_core.sv
// top of the trigger and readout path; wires the trigger manager, FIFOs, arbiter and event builder
`timescale 1ns/10ps
`default_nettype none

module wfd_core
    import wfd_pkg::*;
(
    input  logic       clk125,                // 125 MHz system clock
    input  logic       arst_n,
    input  logic       ext_trig,              // front-panel trigger
    input  chan_mask_t acq_dones,             // done levels from the channels
    input  chan_mask_t chan_en,               // static enable mask
    output chan_mask_t acq_trigs,             // acquisition pulses to the channels
    output chan_mask_t trig_arm,              // arm levels to the channels
    input  chan_mask_t chan_valid,            // channel return streams
    input  chan_beat_t chan_beat [NUM_CHAN],
    output chan_mask_t chan_ready,
    output logic       daq_valid,             // DAQ output stream
    output daq_word_t  daq_word,
    input  logic       daq_ready
);

    // trigger manager to trig_fifo
    logic       tm_num_valid;
    logic       tm_num_ready;
    trig_num_t  tm_num;
    // trig_fifo to event builder
    logic       eb_num_valid;
    logic       eb_num_ready;
    trig_num_t  eb_num;
    // arbiter to event builder
    logic       arb_valid;
    logic       arb_ready;
    chan_beat_t arb_beat;
    // event builder to daq_fifo
    logic       eb_daq_valid;
    logic       eb_daq_ready;
    daq_word_t  eb_daq_word;

    trigger_manager tm (
        .clk125(clk125), .arst_n(arst_n),
        .ext_trig(ext_trig), .acq_dones(acq_dones), .chan_en(chan_en),
        .acq_trigs(acq_trigs), .trig_arm(trig_arm),
        .num_valid(tm_num_valid), .num(tm_num), .num_ready(tm_num_ready)
    );

    // lets the next trigger start while an event is still being read out
    axis_fifo #(.payload_t(trig_num_t), .DEPTH(TRIG_FIFO_DEPTH)) trig_fifo (
        .clk125(clk125), .arst_n(arst_n),
        .in_valid(tm_num_valid), .in_data(tm_num), .in_ready(tm_num_ready),
        .out_valid(eb_num_valid), .out_data(eb_num), .out_ready(eb_num_ready)
    );

    chan_rx_arbiter arb (
        .clk125(clk125), .arst_n(arst_n),
        .chan_valid(chan_valid), .chan_beat(chan_beat), .chan_ready(chan_ready),
        .out_valid(arb_valid), .out_beat(arb_beat), .out_ready(arb_ready)
    );

    event_builder eb (
        .clk125(clk125), .arst_n(arst_n), .chan_en(chan_en),
        .num_valid(eb_num_valid), .num(eb_num), .num_ready(eb_num_ready),
        .beat_valid(arb_valid), .beat(arb_beat), .beat_ready(arb_ready),
        .daq_valid(eb_daq_valid), .daq_word(eb_daq_word), .daq_ready(eb_daq_ready)
    );

    // output buffer, absorbs DAQ back-pressure
    axis_fifo #(.payload_t(daq_word_t), .DEPTH(DAQ_FIFO_DEPTH)) daq_fifo (
        .clk125(clk125), .arst_n(arst_n),
        .in_valid(eb_daq_valid), .in_data(eb_daq_word), .in_ready(eb_daq_ready),
        .out_valid(daq_valid), .out_data(daq_word), .out_ready(daq_ready)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source for wfd_core, 8 ns clock with reset held for 8 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk125,
    output logic arst_n
);

    localparam int HALF_NS      = 4; // 125 MHz
    localparam int RESET_CYCLES = 8;

    initial begin
        clk125 = 1'b0;
        forever #(HALF_NS) clk125 = ~clk125;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk125);
        @(negedge clk125);
        arst_n = 1'b1; // released on a falling edge like every other input
    end

endmodule

`default_nettype wire

//--- tb_wfd_core.sv
// testbench for wfd_core with channel-board models, a DAQ sink with random back-pressure and checks
`timescale 1ns/10ps
`default_nettype none

module tb_wfd_core
    import wfd_pkg::*;
();

    localparam int          NUM_EVENTS     = 20;
    localparam int          CLK_NS         = 8;
    localparam int          RESET_CYCLES   = 8;
    localparam int          MIN_DONE_DELAY = 3;  // cycles from acq pulse to done
    localparam int          MAX_DONE_DELAY = 18;
    localparam int          MAX_PKT_WORDS  = 4;
    localparam logic [31:0] SEED           = 32'h1210;
    localparam chan_mask_t  EN_MASK        = 5'b10111; // channel 3 stays off

    // trigger, acquisition, then every word at about four cycles under back-pressure
    localparam int EVENT_CYCLES = 12 + MAX_DONE_DELAY + 4 * NUM_CHAN * MAX_PKT_WORDS;
    localparam int WATCHDOG_NS  = 2 * CLK_NS * (RESET_CYCLES + NUM_EVENTS * EVENT_CYCLES);

    logic        clk125;
    logic        arst_n;
    logic        ext_trig;
    chan_mask_t  acq_dones;
    chan_mask_t  chan_en;
    chan_mask_t  acq_trigs;
    chan_mask_t  trig_arm;
    chan_mask_t  chan_valid;
    chan_beat_t  chan_beat [NUM_CHAN];
    chan_mask_t  chan_ready;
    logic        daq_valid;
    daq_word_t   daq_word;
    logic        daq_ready;

    int          pkt_count [NUM_CHAN]; // packets finished per channel
    int          acq_count;            // acquisition pulses seen
    int          trig_sent;            // real trigger pulses driven
    int          events_done;          // trailers received by the sink
    chan_mask_t  prev_acq;
    logic        hold_pending;         // word was stalled last cycle
    daq_word_t   held_word;
    logic        in_event;
    int          word_idx;             // position inside the current packet
    int          cur_chan;
    chan_mask_t  seen_mask;            // packets already found in this event
    logic [31:0] rng;                  // sink back-pressure state

    tb_clock_gen clk_gen (.clk125(clk125), .arst_n(arst_n));

    wfd_core DUT (
        .clk125(clk125), .arst_n(arst_n),
        .ext_trig(ext_trig), .acq_dones(acq_dones), .chan_en(chan_en),
        .acq_trigs(acq_trigs), .trig_arm(trig_arm),
        .chan_valid(chan_valid), .chan_beat(chan_beat), .chan_ready(chan_ready),
        .daq_valid(daq_valid), .daq_word(daq_word), .daq_ready(daq_ready)
    );

    //////////////////////////////
    // random numbers and reference packets

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // stateless draw keyed by channel, event and slot
    function automatic logic [31:0] mix(input int c, input int e, input int k);
        return lcg_next(lcg_next(lcg_next(SEED ^ 32'(c)) ^ 32'(e)) ^ 32'(k));
    endfunction

    function automatic logic [31:0] word_value(input int c, input int e, input int k);
        logic [31:0] r;
        r = mix(c, e, k);
        return {4'(c), r[27:0]}; // channel tag in the top nibble
    endfunction

    function automatic int pkt_len(input int c, input int e);
        logic [31:0] r;
        r = mix(c, e, 8);
        return 1 + int'(r[17:16]); // 1 .. MAX_PKT_WORDS
    endfunction

    function automatic int done_delay(input int c, input int e);
        logic [31:0] r;
        r = mix(c, e, 9);
        return MIN_DONE_DELAY + int'(r[19:16]); // up to MAX_DONE_DELAY
    endfunction

    // every enabled channel has sent its packet for event e-1
    function automatic logic packets_done(input int e);
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (chan_en[c] && pkt_count[c] < e) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic stop_failed();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("** Error @ %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    //////////////////////////////
    // channel boards

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        logic       valid_r;
        chan_beat_t beat_r;
        logic       done_r;

        assign chan_valid[i] = valid_r;
        assign chan_beat[i]  = beat_r;
        assign acq_dones[i]  = done_r;

        initial begin
            int ev;
            int nwords;
            valid_r = 1'b0;
            beat_r  = '0;
            done_r  = 1'b0;
            ev      = 0;
            forever begin
                @(posedge clk125);
                if (arst_n && acq_trigs[i]) begin
                    @(negedge clk125);
                    done_r = 1'b0;                          // acquiring
                    repeat (done_delay(i, ev)) @(negedge clk125);
                    done_r = 1'b1;                          // held until next pulse
                    nwords = pkt_len(i, ev);
                    for (int k = 0; k < nwords; k++) begin
                        valid_r     = 1'b1;
                        beat_r.data = word_value(i, ev, k);
                        beat_r.last = (k == nwords - 1);
                        do @(posedge clk125); while (!chan_ready[i]);
                        @(negedge clk125);
                    end
                    valid_r = 1'b0;
                    ev++;
                end
            end
        end
    end

    // DAQ sink with random ready
    initial begin
        rng       = SEED;
        daq_ready = 1'b0;
        forever begin
            @(negedge clk125);
            rng       = lcg_next(rng);
            daq_ready = arst_n && rng[16];
        end
    end

    //////////////////////////////
    // checks

    assert property (@(posedge clk125) disable iff (!arst_n) (acq_trigs & ~chan_en) == '0)
        else value_error("acq_trigs bit set outside chan_en");
    assert property (@(posedge clk125) disable iff (!arst_n)
                     trig_arm == chan_en || trig_arm == '0)
        else value_error($sformatf("trig_arm %b is neither chan_en nor zero", trig_arm));
    assert property (@(posedge clk125) disable iff (!arst_n)
                     $onehot0(chan_ready) && (chan_ready & ~chan_en) == '0)
        else value_error($sformatf("chan_ready %b grants a wrong channel", chan_ready));

    // one accepted DAQ word against the expected event layout
    task automatic check_daq_word(input daq_word_t w);
        int c;
        int ev;
        ev = events_done;
        if (!in_event) begin
            assert (w.header && !w.trailer && w.data == 32'(ev + 1))
                else value_error($sformatf("header word %h, expected number %0d", w, ev + 1));
            in_event  = 1'b1;
            seen_mask = '0;
            word_idx  = 0;
        end else begin
            assert (!w.header) else value_error("header flag inside an event body");
            if (word_idx == 0) begin
                c = int'(w.data[31:28]);
                assert (c < NUM_CHAN && chan_en[c] && !seen_mask[c])
                    else value_error($sformatf("unexpected packet start %h in event %0d",
                                               w.data, ev + 1));
                cur_chan = c;
            end
            assert (w.data == word_value(cur_chan, ev, word_idx))
                else value_error($sformatf("channel %0d word %0d is %h, expected %h", cur_chan,
                                           word_idx, w.data, word_value(cur_chan, ev, word_idx)));
            word_idx++;
            if (word_idx == pkt_len(cur_chan, ev)) begin
                seen_mask[cur_chan] = 1'b1;
                word_idx            = 0;
            end
            assert (w.trailer == (word_idx == 0 && seen_mask == chan_en))
                else value_error($sformatf("trailer flag %b misplaced in event %0d",
                                           w.trailer, ev + 1));
            if (w.trailer) begin
                in_event = 1'b0;
                events_done++;
            end
        end
    endtask

    always @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) pkt_count[c] = 0;
            acq_count    = 0;
            events_done  = 0;
            prev_acq     = '0;
            hold_pending = 1'b0;
            held_word    = '0;
            in_event     = 1'b0;
            word_idx     = 0;
            cur_chan     = 0;
            seen_mask    = '0;
        end else begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (chan_valid[c] && chan_ready[c] && chan_beat[c].last) pkt_count[c]++;
            end
            if (acq_trigs != '0) begin
                acq_count++;
                assert (acq_trigs == chan_en)
                    else value_error($sformatf("acq_trigs %b, expected %b", acq_trigs, chan_en));
                assert (trig_arm == '0)
                    else value_error($sformatf("trig_arm %b during the acq pulse", trig_arm));
                assert (prev_acq == '0) else value_error("acq_trigs high for two cycles");
                assert (acq_count <= trig_sent)
                    else value_error($sformatf("acq pulse %0d without a trigger", acq_count));
            end
            prev_acq = acq_trigs;
            if (hold_pending) begin
                assert (daq_valid && daq_word == held_word)
                    else value_error($sformatf("stalled word %h changed to %h", held_word,
                                               daq_word));
            end
            hold_pending = daq_valid && !daq_ready;
            held_word    = daq_word;
            if (daq_valid && daq_ready) check_daq_word(daq_word);
        end
    end

    //////////////////////////////
    // stimulus

    initial begin
        ext_trig  = 1'b0;
        chan_en   = EN_MASK;
        trig_sent = 0;
        repeat (4) @(negedge clk125);
        assert (acq_trigs == '0 && !daq_valid && chan_ready == '0 && trig_arm == chan_en)
            else value_error("outputs not at their reset values");
        @(posedge arst_n);
        for (int e = 0; e < NUM_EVENTS; e++) begin
            while (!(packets_done(e) && trig_arm == chan_en)) @(negedge clk125);
            ext_trig = 1'b1;
            trig_sent++;
            repeat (2) @(negedge clk125);
            ext_trig = 1'b0;
            while (trig_arm != '0) @(negedge clk125); // acquisition started
            ext_trig = 1'b1;                          // extra edge while disarmed
            repeat (2) @(negedge clk125);
            ext_trig = 1'b0;
        end
        while (events_done < NUM_EVENTS) @(negedge clk125);
        repeat (40) @(negedge clk125);                // room for a stray event to show
        if (acq_count != NUM_EVENTS || events_done != NUM_EVENTS || daq_valid) begin
            $display("run ended with %0d acq pulses and %0d events, or an extra word pending",
                     acq_count, events_done);
            stop_failed();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d of %0d events read out",
                 WATCHDOG_NS, events_done, NUM_EVENTS);
        stop_failed();
    end

endmodule

`default_nettype wire

//--- wfd_core.f
wfd_pkg.sv
trigger_manager.sv
axis_fifo.sv
chan_rx_arbiter.sv
event_builder.sv
wfd_core.sv
tb_clock_gen.sv
tb_wfd_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the wfd_core testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_wfd_core \
    -f wfd_core.f --Mdir obj_dir -o tb_wfd_core > build.log 2>&1 \
    && ./obj_dir/tb_wfd_core > sim.log 2>&1 \
    || echo "build or simulation returned an error, see build.log and sim.log"

if grep -qsx "All checks passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
